/* verilog/batchPkg.sv */
package batchPkg;

    // Stream bits packed into one downsampled input word
    localparam int StreamBits = 12;

    // Width of a ones count over one input word
    localparam int CountWidth = $clog2(StreamBits + 1);

    // Samples per batch and the index that walks them
    localparam int BatchLen = 8;
    localparam int IndexWidth = $clog2(BatchLen);

    // Decoded sample, range -12 to +12
    localparam int SampleWidth = 5;

    // Recursion values and output word
    localparam int AccWidth = 8;

    // Pole factor of one half as an arithmetic shift
    localparam int DecayShift = 1;

    // Consumer FSM encodings
    localparam logic [1:0] StateIdle = 2'd0;
    localparam logic [1:0] StateFwd = 2'd1;
    localparam logic [1:0] StateBwd = 2'd2;

endpackage

/* verilog/sampleDecoder.sv */
`timescale 1ns/100ps

module sampleDecoder import batchPkg::*; (
    input  logic                          clkDS,
    input  logic                          rst,
    input  logic [StreamBits-1:0]         inWord,
    input  logic                          inValid,
    output logic                          inReady,
    output logic signed [SampleWidth-1:0] decSample,
    output logic                          decValid,
    input  logic                          decReady
);

    logic [CountWidth-1:0] ones;
    logic signed [SampleWidth-1:0] sampleNext;
    logic accept;

    // Ones count over the packed stream bits
    always_comb begin
        ones = '0;
        for (int i = 0; i < StreamBits; i++) begin
            ones = ones + CountWidth'(inWord[i]);
        end
    end

    // x = 2 * ones - 12, wraps back into range in SampleWidth bits
    assign sampleNext = SampleWidth'({ones, 1'b0}) - SampleWidth'(StreamBits);

    // Stage takes a new word when empty or when its content leaves
    assign inReady = !decValid || decReady;
    assign accept = inValid && inReady;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            decValid <= 1'b0;
        end else if (accept) begin
            decValid <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clkDS) begin
        if (accept) begin
            decSample <= sampleNext;
        end
    end

    // Held sample must not change until the buffer takes it
    holdStable: assert property (@(posedge clkDS) disable iff (!rst)
        decValid && !decReady |=> decValid && $stable(decSample));

endmodule

/* verilog/batchBuffer.sv */
`timescale 1ns/100ps

module batchBuffer import batchPkg::*; (
    input  logic                          clkDS,
    input  logic                          rst,
    input  logic signed [SampleWidth-1:0] decSample,
    input  logic                          decValid,
    output logic                          decReady,
    output logic                          bankValid,
    input  logic [IndexWidth-1:0]         rdIndex,
    output logic signed [SampleWidth-1:0] rdSample,
    input  logic                          bankDone
);

    localparam logic [IndexWidth-1:0] LastIdx = IndexWidth'(BatchLen - 1);

    // Two banks, one filling while the other is read
    logic signed [SampleWidth-1:0] mem [2][BatchLen];

    logic [IndexWidth-1:0] wrIdx;
    logic fillBank;
    logic readBank;
    logic [1:0] full;
    logic writeEn;

    // Producer stalls only while the bank to fill is still full
    assign decReady = !full[fillBank];
    assign writeEn = decValid && decReady;

    // Consumer sees a bank once all its samples are in
    assign bankValid = full[readBank];

    // Read port is combinational, any order
    assign rdSample = mem[readBank][rdIndex];

    always_ff @(posedge clkDS) begin
        if (writeEn) begin
            mem[fillBank][wrIdx] <= decSample;
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            wrIdx <= '0;
            fillBank <= 1'b0;
            readBank <= 1'b0;
            full <= '0;
        end else begin
            if (writeEn) begin
                wrIdx <= wrIdx + 1'b1;
                // Eighth write closes the bank and moves to the other one
                if (wrIdx == LastIdx) begin
                    full[fillBank] <= 1'b1;
                    fillBank <= ~fillBank;
                end
            end
            // Consumer finished, free the bank and read the next one
            if (bankDone) begin
                full[readBank] <= 1'b0;
                readBank <= ~readBank;
            end
        end
    end

    // A bank part way through filling is never marked full
    noWriteFull: assert property (@(posedge clkDS) disable iff (!rst)
        (wrIdx != '0) |-> !full[fillBank]);

    // Consumer may only release a bank it was handed
    doneWhileValid: assert property (@(posedge clkDS) disable iff (!rst)
        bankDone |-> bankValid);

endmodule

/* verilog/batchRecursion.sv */
`timescale 1ns/100ps

module batchRecursion import batchPkg::*; (
    input  logic                          clkDS,
    input  logic                          rst,
    input  logic                          bankValid,
    output logic [IndexWidth-1:0]         rdIndex,
    input  logic signed [SampleWidth-1:0] rdSample,
    output logic                          bankDone,
    output logic [AccWidth-1:0]           out,
    output logic                          outValid,
    output logic                          outLast,
    input  logic                          outReady
);

    localparam logic [IndexWidth-1:0] LastIdx = IndexWidth'(BatchLen - 1);

    logic [1:0] state;
    logic [IndexWidth-1:0] idx;
    logic bwdDone;

    // Forward values kept for the backward pass
    logic signed [AccWidth-1:0] fwdMem [BatchLen];
    logic signed [AccWidth-1:0] fwdPrev;
    logic signed [AccWidth-1:0] bwdPrev;

    logic signed [AccWidth-1:0] xExt;
    logic signed [AccWidth-1:0] fwdVal;
    logic signed [AccWidth-1:0] bwdVal;
    logic signed [AccWidth-1:0] sum;
    logic loadOut;
    logic xfer;

    assign rdIndex = idx;

    always_comb begin
        xExt = {{(AccWidth - SampleWidth){rdSample[SampleWidth-1]}}, rdSample};
        // First value of each pass is the sample itself
        fwdVal = (idx == '0) ? xExt : xExt + (fwdPrev >>> DecayShift);
        bwdVal = (idx == LastIdx) ? xExt : xExt + (bwdPrev >>> DecayShift);
        // Sample appears in both passes and is counted once
        sum = fwdMem[idx] + bwdVal - xExt;
    end

    // Output register refills when empty or draining this cycle
    assign loadOut = (state == StateBwd) && !bwdDone && (!outValid || outReady);
    assign xfer = outValid && outReady;
    assign bankDone = xfer && outLast;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= StateIdle;
            idx <= '0;
            bwdDone <= 1'b0;
            outValid <= 1'b0;
            outLast <= 1'b0;
        end else begin
            case (state)
                StateIdle: begin
                    if (bankValid) begin
                        state <= StateFwd;
                        idx <= '0;
                    end
                end
                StateFwd: begin
                    if (idx == LastIdx) begin
                        // Backward starts from the last sample of this batch
                        state <= StateBwd;
                        bwdDone <= 1'b0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                StateBwd: begin
                    if (loadOut) begin
                        outValid <= 1'b1;
                        outLast <= (idx == '0);
                        if (idx == '0) begin
                            bwdDone <= 1'b1;
                        end else begin
                            idx <= idx - 1'b1;
                        end
                    end else if (xfer) begin
                        outValid <= 1'b0;
                        outLast <= 1'b0;
                        if (outLast) begin
                            state <= StateIdle;
                        end
                    end
                end
                default: begin
                    state <= StateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clkDS) begin
        if (state == StateFwd) begin
            fwdMem[idx] <= fwdVal;
            fwdPrev <= fwdVal;
        end
        if (loadOut) begin
            bwdPrev <= bwdVal;
            // Offset binary with the sign bit inverted
            out <= {~sum[AccWidth-1], sum[AccWidth-2:0]};
        end
    end

    lastNeedsValid: assert property (@(posedge clkDS) disable iff (!rst)
        outLast |-> outValid && (state == StateBwd));

endmodule

/* verilog/batchDecoderTop.sv */
`timescale 1ns/100ps

module batchDecoderTop import batchPkg::*; (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic [StreamBits-1:0] inWord,
    input  logic                  inValid,
    output logic                  inReady,
    output logic [AccWidth-1:0]   out,
    output logic                  outValid,
    output logic                  outLast,
    input  logic                  outReady
);

    // Producer to buffer
    logic signed [SampleWidth-1:0] decSample;
    logic decValid;
    logic decReady;

    // Buffer to consumer
    logic bankValid;
    logic [IndexWidth-1:0] rdIndex;
    logic signed [SampleWidth-1:0] rdSample;
    logic bankDone;

    sampleDecoder decoder0 (
        .clkDS(clkDS),
        .rst(rst),
        .inWord(inWord),
        .inValid(inValid),
        .inReady(inReady),
        .decSample(decSample),
        .decValid(decValid),
        .decReady(decReady)
    );

    batchBuffer buffer0 (
        .clkDS(clkDS),
        .rst(rst),
        .decSample(decSample),
        .decValid(decValid),
        .decReady(decReady),
        .bankValid(bankValid),
        .rdIndex(rdIndex),
        .rdSample(rdSample),
        .bankDone(bankDone)
    );

    batchRecursion recursion0 (
        .clkDS(clkDS),
        .rst(rst),
        .bankValid(bankValid),
        .rdIndex(rdIndex),
        .rdSample(rdSample),
        .bankDone(bankDone),
        .out(out),
        .outValid(outValid),
        .outLast(outLast),
        .outReady(outReady)
    );

endmodule

/* test/batchChecker.sv */
`timescale 1ns/100ps

module batchChecker import batchPkg::*; (
    input  logic                clkDS,
    input  logic                rst,
    input  logic                inValid,
    input  logic                inReady,
    input  logic [AccWidth-1:0] out,
    input  logic                outValid,
    input  logic                outLast,
    input  logic                outReady,
    input  logic                expPush,
    input  logic [AccWidth-1:0] expData,
    output int                  outCount,
    output int                  valueErrors,
    output int                  framingErrors,
    output int                  holdErrors,
    output int                  otherErrors
);

    // Decoder stage plus two full banks
    localparam int MaxInFlight = 2 * BatchLen + 1;
    localparam int ResetCycles = 3;

    logic [AccWidth-1:0] expQ[$];
    int inCount;
    int sinceReset;
    logic prevStall;
    logic [AccWidth-1:0] prevOut;
    logic prevLast;
    logic [AccWidth-1:0] expected;
    logic expLast;

    always @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            outCount = 0;
            valueErrors = 0;
            framingErrors = 0;
            holdErrors = 0;
            otherErrors = 0;
            inCount = 0;
            sinceReset = 0;
            prevStall = 1'b0;
        end else begin
            if (expPush) begin
                expQ.push_back(expData);
            end
            // Idle state in the first cycles out of reset
            if (sinceReset < ResetCycles) begin
                sinceReset++;
                if (outValid || outLast || !inReady) begin
                    $display("Wrong state after reset: outValid %0b outLast %0b inReady %0b",
                        outValid, outLast, inReady);
                    otherErrors++;
                end
            end
            // A stalled output must still be there, unchanged
            if (prevStall) begin
                if (!outValid) begin
                    $display("Output withdrawn before it was taken, outValid dropped");
                    holdErrors++;
                end else if (out != prevOut || outLast != prevLast) begin
                    $display("FAILED hold: expected 8'h%02h last %0b actual 8'h%02h last %0b",
                        prevOut, prevLast, out, outLast);
                    holdErrors++;
                end
            end
            prevStall = outValid && !outReady;
            prevOut = out;
            prevLast = outLast;
            if (outValid && outReady) begin
                // Every eighth output closes a batch
                expLast = (outCount % BatchLen) == BatchLen - 1;
                if (expQ.size() == 0) begin
                    $display("Output 8'h%02h arrived after all expected values were used", out);
                    otherErrors++;
                end else begin
                    expected = expQ.pop_front();
                    if (out != expected) begin
                        $display("FAILED values: output %0d expected 8'h%02h actual 8'h%02h",
                            outCount, expected, out);
                        valueErrors++;
                    end
                end
                if (outLast != expLast) begin
                    $display("FAILED framing: output %0d expected outLast %0b actual %0b",
                        outCount, expLast, outLast);
                    framingErrors++;
                end
                outCount++;
            end
            if (inValid && inReady) begin
                inCount++;
                if (inCount - outCount > MaxInFlight) begin
                    $display("DUT accepted %0d words while only %0d left, more than it can hold",
                        inCount, outCount);
                    otherErrors++;
                end
            end
        end
    end

endmodule

/* test/batchDecoderTb.sv */
`timescale 1ns/100ps

module batchDecoderTb import batchPkg::*; ();

    localparam int InTimeout = 200;
    localparam int StallTimeout = 400;
    localparam int StallHold = 12;
    localparam int DrainTimeout = 2000;
    localparam int DrainIdle = 20;

    logic clkDS;
    logic rst;
    logic [StreamBits-1:0] inWord;
    logic inValid;
    logic inReady;
    logic [AccWidth-1:0] out;
    logic outValid;
    logic outLast;
    logic outReady;
    logic expPush;
    logic [AccWidth-1:0] expData;

    int outCount;
    int valueErrors;
    int framingErrors;
    int holdErrors;
    int otherErrors;
    int timeoutErrors;
    int setupErrors;
    int expTotal;
    integer seed;
    bit abort;

    logic [StreamBits-1:0] inWords[$];
    logic [AccWidth-1:0] expWords[$];

    batchDecoderTop dut0 (
        .clkDS(clkDS),
        .rst(rst),
        .inWord(inWord),
        .inValid(inValid),
        .inReady(inReady),
        .out(out),
        .outValid(outValid),
        .outLast(outLast),
        .outReady(outReady)
    );

    batchChecker checker0 (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .out(out),
        .outValid(outValid),
        .outLast(outLast),
        .outReady(outReady),
        .expPush(expPush),
        .expData(expData),
        .outCount(outCount),
        .valueErrors(valueErrors),
        .framingErrors(framingErrors),
        .holdErrors(holdErrors),
        .otherErrors(otherErrors)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    task automatic loadStimulus();
        int fd;
        int status;
        string line;
        byte tag;
        logic [31:0] value;
        fd = $fopen("test/batchStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/batchStimulus.txt");
            setupErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                // Skip blank lines and comment lines
                if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    tag = line.getc(0);
                    status = $sscanf(line.substr(1, line.len() - 1), "%h", value);
                    if (tag == "I") begin
                        inWords.push_back(value[StreamBits-1:0]);
                    end else if (tag == "E") begin
                        expWords.push_back(value[AccWidth-1:0]);
                    end
                end
            end
            $fclose(fd);
            if (inWords.size() == 0 || expWords.size() == 0) begin
                $display("Stimulus file holds no input words or no expected outputs");
                setupErrors++;
            end
        end
    endtask

    task automatic sendWord(input logic [StreamBits-1:0] word);
        int waitCycles;
        inWord = word;
        inValid = 1'b1;
        waitCycles = 0;
        // inReady moves only on rising edges, so this value holds for the next one
        while (!inReady && waitCycles < InTimeout) begin
            @(negedge clkDS);
            waitCycles++;
        end
        if (!inReady) begin
            $display("Timeout: inReady stayed low for %0d cycles", InTimeout);
            timeoutErrors++;
            abort = 1'b1;
        end
        @(negedge clkDS);
        inValid = 1'b0;
    endtask

    task automatic driveInputs();
        int gap;
        int i;
        i = 0;
        while (i < inWords.size() && !abort) begin
            if (($random(seed) & 3) == 0) begin
                gap = 1 + ($random(seed) & 3);
                repeat (gap) @(negedge clkDS);
            end
            sendWord(inWords[i]);
            i++;
        end
    endtask

    task automatic controlReady();
        int waitCycles;
        // Long output stall until the buffer backs up to the input
        outReady = 1'b0;
        waitCycles = 0;
        while (inReady && waitCycles < StallTimeout) begin
            @(negedge clkDS);
            waitCycles++;
        end
        if (inReady) begin
            $display("Timeout: inReady never went low during the output stall");
            timeoutErrors++;
        end
        repeat (StallHold) @(negedge clkDS);
        waitCycles = 0;
        while (outCount < expTotal && waitCycles < DrainTimeout) begin
            outReady = ($random(seed) & 3) != 0;
            @(negedge clkDS);
            waitCycles++;
        end
        if (outCount < expTotal) begin
            $display("Timeout: only %0d of %0d outputs arrived", outCount, expTotal);
            timeoutErrors++;
        end
        outReady = 1'b1;
    endtask

    initial begin
        seed = 32'h7f50;
        rst = 1'b0;
        inWord = '0;
        inValid = 1'b0;
        outReady = 1'b0;
        expPush = 1'b0;
        expData = '0;
        timeoutErrors = 0;
        setupErrors = 0;
        abort = 1'b0;
        loadStimulus();
        expTotal = expWords.size();
        repeat (2) @(posedge clkDS);
        @(negedge clkDS);
        rst = 1'b1;
        // Expected outputs go to the checker in emission order
        foreach (expWords[i]) begin
            @(negedge clkDS);
            expData = expWords[i];
            expPush = 1'b1;
        end
        @(negedge clkDS);
        expPush = 1'b0;
        if (setupErrors == 0) begin
            fork
                driveInputs();
                controlReady();
            join
            // Room for any surplus output to show up
            repeat (DrainIdle) @(negedge clkDS);
        end
        $display("Errors: values %0d, framing %0d, hold %0d, other %0d, timeouts %0d, setup %0d",
            valueErrors, framingErrors, holdErrors, otherErrors, timeoutErrors, setupErrors);
        if (valueErrors + framingErrors + holdErrors + otherErrors + timeoutErrors
                + setupErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* test/batchStimulus.txt */
# Columns: tag, then hex value
# I is a 12-bit input word, E an expected 8-bit output in emission order (index 7 down to 0)
I FFF
I 000
I 0FF
I 00F
I 3F0
I FF0
I 001
I FFE
E 85
E 7C
E 80
E 7E
E 7C
E 7F
E 7B
E 86
I FFF
I FFF
I FFF
I FFE
I 7FF
I AAA
I 555
I 800
E 78
E 80
E 87
E 92
E 98
E 9C
E 9B
E 96
I 000
I 100
I 000
I 003
I 000
I 0F0
I 3C7
I 000
E 71
E 74
E 6F
E 68
E 66
E 64
E 66
E 6A

/* sources.f */
verilog/batchPkg.sv
verilog/sampleDecoder.sv
verilog/batchBuffer.sv
verilog/batchRecursion.sv
verilog/batchDecoderTop.sv
test/batchChecker.sv
test/batchDecoderTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the batch decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module batchDecoderTb \
    --Mdir obj_dir -o batchDecoderSim \
    -f sources.f

simOutput=$(./obj_dir/batchDecoderSim)
echo "$simOutput"

if echo "$simOutput" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
